// File: rtl/mem_pkg.sv
// Memory controller shared types
`default_nettype none

package mem_pkg;

	////////////////////
	// CPU side

	// One CPU bus cycle, strobes have no handshake
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} cpu_bus_t;

	// Decoded target of a CPU access
	typedef enum logic [1:0] {
		REGION_WRAM,
		REGION_PPU,
		REGION_JOY,
		REGION_NONE
	} region_e;

	// PPU register index, address bits 2:0
	typedef enum logic [2:0] {
		REG_CTRL1,
		REG_CTRL2,
		REG_STATUS,
		REG_OAM_ADDR,
		REG_OAM_DATA,
		REG_SCROLL,
		REG_VADDR,
		REG_VDATA
	} ppu_reg_e;

	// Decoded access
	// offset holds the folded work RAM address, or the pad number in bit 0
	typedef struct packed {
		region_e     region;
		ppu_reg_e    reg_idx;
		logic [10:0] offset;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} cpu_acc_t;

	////////////////////
	// PPU side

	// Nametable mirroring
	typedef enum logic {
		MIRROR_H,
		MIRROR_V
	} mirror_e;

	// Button levels of both pads
	typedef logic [1:0][7:0] joy_buttons_t;

	// Reads from here up bypass the read buffer
	localparam logic [15:0] PALETTE_BASE = 16'h3F00;

endpackage

`default_nettype wire

// File: rtl/cpu_addr_map.sv
// CPU address decoder
`timescale 1ns/1ps
`default_nettype none

module cpu_addr_map import mem_pkg::*; (
	input  cpu_bus_t cpu_bus,
	output cpu_acc_t acc
);

	always_comb begin
		// Data and strobes pass straight through
		acc.wdata = cpu_bus.wdata;
		acc.wr = cpu_bus.wr;
		acc.rd = cpu_bus.rd;

		// Defaults for unmapped space
		acc.region = REGION_NONE;
		acc.reg_idx = REG_CTRL1;
		acc.offset = 11'd0;

		case (cpu_bus.addr[15:13])
			// 0x0000-0x1FFF
			3'b000: begin
				// 2 KB repeated four times
				acc.region = REGION_WRAM;
				acc.offset = cpu_bus.addr[10:0];
			end
			// 0x2000-0x3FFF
			3'b001: begin
				// Eight registers repeated every 8 bytes
				acc.region = REGION_PPU;
				acc.reg_idx = ppu_reg_e'(cpu_bus.addr[2:0]);
			end
			default: begin
				// 0x4016 and 0x4017 only
				if (cpu_bus.addr[15:1] == 15'h200B) begin
					acc.region = REGION_JOY;
					acc.offset = {10'd0, cpu_bus.addr[0]};
				end
				// Cartridge, mapper and audio space stay unmapped
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/vram_mirror.sv
// Video address mirroring
`timescale 1ns/1ps
`default_nettype none

module vram_mirror import mem_pkg::*; #(
	parameter int VRAM_AW = 14
) (
	input  logic [15:0]        addr,
	input  mirror_e            mode,
	output logic [VRAM_AW-1:0] index
);

	logic [15:0] folded;

	always_comb begin
		// 16 KB space repeats above 0x3FFF
		folded = {2'b00, addr[13:0]};

		if (folded >= PALETTE_BASE) begin
			// Palette repeats every 32 bytes
			folded[7:5] = 3'b000;
			// Sprite backdrop entries alias the background ones
			if (folded[1:0] == 2'b00) begin
				folded[4] = 1'b0;
			end
		end else if (folded[13]) begin
			// 0x3000-0x3EFF lands on 0x2000
			folded[12] = 1'b0;
			// Two physical tables, quadrant bit chosen by mode
			if (mode == MIRROR_H) begin
				folded[10] = 1'b0;
			end else begin
				folded[11] = 1'b0;
			end
		end
	end

	assign index = folded[VRAM_AW-1:0];

endmodule

`default_nettype wire

// File: rtl/dual_port_ram.sv
// Two port synchronous RAM
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
	parameter int DEPTH = 256,
	parameter int WIDTH = 8,
	localparam int AW = $clog2(DEPTH)
) (
	input  logic             clk,
	// CPU port
	input  logic [AW-1:0]    a_addr,
	input  logic [WIDTH-1:0] a_wdata,
	input  logic             a_we,
	output logic [WIDTH-1:0] a_rdata,
	// Read only port
	input  logic [AW-1:0]    b_addr,
	output logic [WIDTH-1:0] b_rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
		end
		// Old data on a same-address write
		a_rdata <= mem[a_addr];
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

// File: rtl/ppu_reg_file.sv
// PPU register file
`timescale 1ns/1ps
`default_nettype none

module ppu_reg_file import mem_pkg::*; #(
	parameter int VRAM_AW = 14
) (
	input  logic               clk,
	input  logic               rst,
	input  cpu_acc_t           acc,
	input  logic [7:0]         ppu_status,
	input  mirror_e            mirror_mode,
	input  logic [7:0]         vram_rdata,
	input  logic [7:0]         oam_rdata,
	output logic [7:0]         ppu_ctrl1,
	output logic [7:0]         ppu_ctrl2,
	output logic [15:0]        ppu_scroll,
	output logic [VRAM_AW-1:0] vram_cpu_addr,
	output logic               vram_we,
	output logic [7:0]         oam_cpu_addr,
	output logic               oam_we,
	output logic [7:0]         reg_rdata,
	output logic               status_read
);

	logic       ppu_sel;
	logic       ppu_wr;
	logic       ppu_rd;
	logic       vdata_acc;
	logic       oam_acc;
	logic       toggle;
	logic [15:0] vaddr;
	logic [7:0] vbuf;
	logic       vbuf_pend;
	logic [7:0] vbuf_cur;
	logic       pal_hit;
	logic [7:0] rd_byte;
	ppu_reg_e   idx_q;
	logic       pal_q;
	logic [7:0] hold_q;
	logic [7:0] oam_addr_q;

	////////////////////
	// Access decode

	assign ppu_sel = (acc.region == REGION_PPU);
	assign ppu_wr = ppu_sel && acc.wr;
	assign ppu_rd = ppu_sel && acc.rd;

	// Data ports move their address on reads and writes
	assign vdata_acc = ppu_sel && (acc.reg_idx == REG_VDATA) && (acc.wr || acc.rd);
	assign oam_acc = ppu_sel && (acc.reg_idx == REG_OAM_DATA) && (acc.wr || acc.rd);

	assign vram_we = ppu_wr && (acc.reg_idx == REG_VDATA);
	assign oam_we = ppu_wr && (acc.reg_idx == REG_OAM_DATA);
	assign status_read = ppu_rd && (acc.reg_idx == REG_STATUS);

	// CPU side VRAM index
	vram_mirror #(.VRAM_AW(VRAM_AW)) u_cpu_mirror (
		.addr  (vaddr),
		.mode  (mirror_mode),
		.index (vram_cpu_addr)
	);

	assign oam_cpu_addr = oam_addr_q;

	////////////////////
	// Control state

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_ctrl1 <= 8'h00;
			ppu_ctrl2 <= 8'h00;
			ppu_scroll <= 16'h0000;
			vaddr <= 16'h0000;
			toggle <= 1'b0;
			oam_addr_q <= 8'h00;
		end else begin
			if (ppu_wr) begin
				case (acc.reg_idx)
					REG_CTRL1: ppu_ctrl1 <= acc.wdata;
					REG_CTRL2: ppu_ctrl2 <= acc.wdata;
					REG_OAM_ADDR: oam_addr_q <= acc.wdata;
					REG_SCROLL: begin
						// X first, then Y
						if (toggle) begin
							ppu_scroll[15:8] <= acc.wdata;
						end else begin
							ppu_scroll[7:0] <= acc.wdata;
						end
						toggle <= ~toggle;
					end
					REG_VADDR: begin
						// High byte first
						if (toggle) begin
							vaddr[7:0] <= acc.wdata;
						end else begin
							vaddr[15:8] <= acc.wdata;
						end
						toggle <= ~toggle;
					end
					default: begin
					end
				endcase
			end

			// Status read restarts the two-write sequence
			if (status_read) begin
				toggle <= 1'b0;
			end

			// Step of 32 walks down a nametable column
			if (vdata_acc) begin
				vaddr <= vaddr + (ppu_ctrl1[2] ? 16'd32 : 16'd1);
			end

			// Wraps at 256
			if (oam_acc) begin
				oam_addr_q <= oam_addr_q + 8'd1;
			end
		end
	end

	////////////////////
	// Read buffer

	// RAM byte of the last data read lands one cycle late
	assign vbuf_cur = vbuf_pend ? vram_rdata : vbuf;
	assign pal_hit = ({2'b00, vaddr[13:0]} >= PALETTE_BASE);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vbuf <= 8'h00;
			vbuf_pend <= 1'b0;
			idx_q <= REG_CTRL1;
			pal_q <= 1'b0;
		end else begin
			if (vbuf_pend) begin
				vbuf <= vram_rdata;
			end
			vbuf_pend <= ppu_rd && (acc.reg_idx == REG_VDATA);
			if (ppu_rd) begin
				idx_q <= acc.reg_idx;
				pal_q <= pal_hit;
			end
		end
	end

	// Register byte as it stood at the sample edge
	always_comb begin
		case (acc.reg_idx)
			REG_CTRL1: rd_byte = ppu_ctrl1;
			REG_CTRL2: rd_byte = ppu_ctrl2;
			REG_STATUS: rd_byte = ppu_status;
			REG_OAM_ADDR: rd_byte = oam_addr_q;
			REG_SCROLL: rd_byte = ppu_scroll[7:0];
			REG_VADDR: rd_byte = vaddr[7:0];
			REG_VDATA: rd_byte = vbuf_cur;
			default: rd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ppu_rd) begin
			hold_q <= rd_byte;
		end
	end

	// Sprite data and palette bytes come straight from RAM
	always_comb begin
		if (idx_q == REG_OAM_DATA) begin
			reg_rdata = oam_rdata;
		end else if ((idx_q == REG_VDATA) && pal_q) begin
			reg_rdata = vram_rdata;
		end else begin
			reg_rdata = hold_q;
		end
	end

endmodule

`default_nettype wire

// File: rtl/joypad_shift.sv
// Joypad shift register
`timescale 1ns/1ps
`default_nettype none

module joypad_shift import mem_pkg::*; #(
	parameter int PAD_ID = 0
) (
	input  logic       clk,
	input  logic       rst,
	input  cpu_acc_t   acc,
	input  logic [7:0] buttons,
	output logic       bit_out
);

	logic       strobe;
	logic       strobe_wr;
	logic       pad_rd;
	logic [7:0] shift;
	logic       bit_q;

	// Latch strobe lives at 0x4016 for both pads
	assign strobe_wr = (acc.region == REGION_JOY) && acc.wr && !acc.offset[0];
	assign pad_rd = (acc.region == REGION_JOY) && acc.rd && (acc.offset[0] == 1'(PAD_ID));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			strobe <= 1'b0;
			shift <= 8'h00;
			bit_q <= 1'b0;
		end else begin
			if (strobe_wr) begin
				strobe <= acc.wdata[0];
			end
			if (pad_rd) begin
				// Hold the bit seen at the sample edge
				bit_q <= shift[0];
			end
			if (strobe) begin
				shift <= buttons;
			end else if (pad_rd) begin
				// Ones after the eighth button
				shift <= {1'b1, shift[7:1]};
			end
		end
	end

	assign bit_out = bit_q;

endmodule

`default_nettype wire

// File: rtl/cpu_read_mux.sv
// CPU read data select
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux import mem_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  cpu_acc_t   acc,
	input  logic [7:0] wram_rdata,
	input  logic [7:0] reg_rdata,
	input  logic [1:0] joy_bits,
	output logic [7:0] cpu_data_out
);

	region_e src_q;
	logic    pad_q;

	// Source of the read sampled at the last edge
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			src_q <= REGION_NONE;
			pad_q <= 1'b0;
		end else begin
			src_q <= acc.rd ? acc.region : REGION_NONE;
			if (acc.rd && (acc.region == REGION_JOY)) begin
				pad_q <= acc.offset[0];
			end
		end
	end

	always_comb begin
		case (src_q)
			REGION_WRAM: cpu_data_out = wram_rdata;
			REGION_PPU: cpu_data_out = reg_rdata;
			// Serial bit on D0 only
			REGION_JOY: cpu_data_out = {7'd0, joy_bits[pad_q]};
			default: cpu_data_out = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/mem_decode.sv
// CPU and PPU memory controller
`timescale 1ns/1ps
`default_nettype none

module mem_decode import mem_pkg::*; #(
	parameter int WRAM_AW = 11,
	parameter int VRAM_AW = 14
) (
	input  logic         clk,
	input  logic         rst,
	// CPU bus
	input  cpu_bus_t     cpu_bus,
	output logic [7:0]   cpu_data_out,
	// PPU registers
	output logic [7:0]   ppu_ctrl1,
	output logic [7:0]   ppu_ctrl2,
	input  logic [7:0]   ppu_status,
	output logic         ppu_status_read,
	output logic [15:0]  ppu_scroll,
	// PPU memory ports
	input  logic [15:0]  vram_ppu_addr,
	output logic [7:0]   vram_ppu_data,
	input  logic [7:0]   oam_ppu_addr,
	output logic [7:0]   oam_ppu_data,
	// Board inputs
	input  joy_buttons_t joy_buttons,
	input  mirror_e      mirror_mode
);

	cpu_acc_t           acc;
	logic               wram_we;
	logic [7:0]         wram_rdata;
	logic [VRAM_AW-1:0] vram_cpu_addr;
	logic [VRAM_AW-1:0] vram_ppu_index;
	logic               vram_we;
	logic [7:0]         vram_rdata;
	logic [7:0]         oam_cpu_addr;
	logic               oam_we;
	logic [7:0]         oam_rdata;
	logic [7:0]         reg_rdata;
	logic [1:0]         joy_bits;

	cpu_addr_map u_map (
		.cpu_bus (cpu_bus),
		.acc     (acc)
	);

	////////////////////
	// Memories

	assign wram_we = (acc.region == REGION_WRAM) && acc.wr;

	// Work RAM, second port idle
	dual_port_ram #(.DEPTH(2 ** WRAM_AW), .WIDTH(8)) u_wram (
		.clk     (clk),
		.a_addr  (acc.offset[WRAM_AW-1:0]),
		.a_wdata (acc.wdata),
		.a_we    (wram_we),
		.a_rdata (wram_rdata),
		.b_addr  ('0),
		.b_rdata ()
	);

	vram_mirror #(.VRAM_AW(VRAM_AW)) u_ppu_mirror (
		.addr  (vram_ppu_addr),
		.mode  (mirror_mode),
		.index (vram_ppu_index)
	);

	dual_port_ram #(.DEPTH(2 ** VRAM_AW), .WIDTH(8)) u_vram (
		.clk     (clk),
		.a_addr  (vram_cpu_addr),
		.a_wdata (acc.wdata),
		.a_we    (vram_we),
		.a_rdata (vram_rdata),
		.b_addr  (vram_ppu_index),
		.b_rdata (vram_ppu_data)
	);

	// Sprite attributes
	dual_port_ram #(.DEPTH(256), .WIDTH(8)) u_oam (
		.clk     (clk),
		.a_addr  (oam_cpu_addr),
		.a_wdata (acc.wdata),
		.a_we    (oam_we),
		.a_rdata (oam_rdata),
		.b_addr  (oam_ppu_addr),
		.b_rdata (oam_ppu_data)
	);

	////////////////////
	// Registers and pads

	ppu_reg_file #(.VRAM_AW(VRAM_AW)) u_regs (
		.clk           (clk),
		.rst           (rst),
		.acc           (acc),
		.ppu_status    (ppu_status),
		.mirror_mode   (mirror_mode),
		.vram_rdata    (vram_rdata),
		.oam_rdata     (oam_rdata),
		.ppu_ctrl1     (ppu_ctrl1),
		.ppu_ctrl2     (ppu_ctrl2),
		.ppu_scroll    (ppu_scroll),
		.vram_cpu_addr (vram_cpu_addr),
		.vram_we       (vram_we),
		.oam_cpu_addr  (oam_cpu_addr),
		.oam_we        (oam_we),
		.reg_rdata     (reg_rdata),
		.status_read   (ppu_status_read)
	);

	// 0x4016 and 0x4017
	for (genvar i = 0; i < 2; i++) begin : g_pad
		joypad_shift #(.PAD_ID(i)) u_pad (
			.clk     (clk),
			.rst     (rst),
			.acc     (acc),
			.buttons (joy_buttons[i]),
			.bit_out (joy_bits[i])
		);
	end

	cpu_read_mux u_rmux (
		.clk          (clk),
		.rst          (rst),
		.acc          (acc),
		.wram_rdata   (wram_rdata),
		.reg_rdata    (reg_rdata),
		.joy_bits     (joy_bits),
		.cpu_data_out (cpu_data_out)
	);

endmodule

`default_nettype wire

// File: test/mem_decode_chk.sv
// Bus controller assertions
`timescale 1ns/1ps
`default_nettype none

module mem_decode_chk import mem_pkg::*; (
	input logic       clk,
	input logic       rst,
	input cpu_bus_t   cpu_bus,
	input logic       ppu_status_read,
	input logic [7:0] cpu_data_out
);

	logic status_addr;

	// 0x2002 and its mirrors
	assign status_addr = (cpu_bus.addr[15:13] == 3'b001) && (cpu_bus.addr[2:0] == 3'd2);

	// Pulse only with a status read
	a_status_src: assert property (@(posedge clk) disable iff (!rst)
		ppu_status_read |-> (cpu_bus.rd && status_addr))
		else $error("status pulse without a status read");

	// Single cycle pulse
	a_status_len: assert property (@(posedge clk) disable iff (!rst)
		ppu_status_read |=> !ppu_status_read)
		else $error("status pulse longer than one cycle");

	a_strobes: assert property (@(posedge clk) disable iff (!rst)
		!(cpu_bus.wr && cpu_bus.rd))
		else $error("write and read strobes high together");

	// Read byte valid the cycle after sampling
	a_rdata_known: assert property (@(posedge clk) disable iff (!rst)
		cpu_bus.rd |=> !$isunknown(cpu_data_out))
		else $error("read data unknown after a read");

endmodule

bind mem_decode mem_decode_chk u_chk (
	.clk             (clk),
	.rst             (rst),
	.cpu_bus         (cpu_bus),
	.ppu_status_read (ppu_status_read),
	.cpu_data_out    (cpu_data_out)
);

`default_nettype wire

// File: test/tb_mem_decode.sv
// CPU bus controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_decode import mem_pkg::*; ();

	localparam int PERIOD = 100;
	localparam int DRIVE_DLY = 10;

	// Cycle budget per test, generous against the bus task lengths
	localparam int WRAM_CYC = 40;
	localparam int REG_CYC = 30;
	localparam int VRAM_CYC = 120;
	localparam int MIRROR_CYC = 40;
	localparam int OAM_CYC = 40;
	localparam int JOY_CYC = 60;
	localparam int MARGIN_CYC = 100;
	localparam int RUN_CYC = 2 + WRAM_CYC + REG_CYC + VRAM_CYC + MIRROR_CYC
		+ OAM_CYC + JOY_CYC + MARGIN_CYC;

	logic         clk;
	logic         rst;
	cpu_bus_t     cpu_bus;
	logic [7:0]   cpu_data_out;
	logic [7:0]   ppu_ctrl1;
	logic [7:0]   ppu_ctrl2;
	logic [7:0]   ppu_status;
	logic         ppu_status_read;
	logic [15:0]  ppu_scroll;
	logic [15:0]  vram_ppu_addr;
	logic [7:0]   vram_ppu_data;
	logic [7:0]   oam_ppu_addr;
	logic [7:0]   oam_ppu_data;
	joy_buttons_t joy_buttons;
	mirror_e      mirror_mode;

	integer seed = 32'h21fcfcb4;
	int     errors;
	int     err_mark;
	int     tests_run;
	int     tests_failed;
	// Status pulse seen inside the last read strobe
	logic   status_pulse;

	mem_decode #(.WRAM_AW(11), .VRAM_AW(14)) dut (
		.clk             (clk),
		.rst             (rst),
		.cpu_bus         (cpu_bus),
		.cpu_data_out    (cpu_data_out),
		.ppu_ctrl1       (ppu_ctrl1),
		.ppu_ctrl2       (ppu_ctrl2),
		.ppu_status      (ppu_status),
		.ppu_status_read (ppu_status_read),
		.ppu_scroll      (ppu_scroll),
		.vram_ppu_addr   (vram_ppu_addr),
		.vram_ppu_data   (vram_ppu_data),
		.oam_ppu_addr    (oam_ppu_addr),
		.oam_ppu_data    (oam_ppu_data),
		.joy_buttons     (joy_buttons),
		.mirror_mode     (mirror_mode)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Watchdog
	initial begin
		#(RUN_CYC * PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", RUN_CYC);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// Bus helpers

	// One write strobe cycle
	// Starts and ends just after the drive delay
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_bus = '{addr: addr, wdata: data, wr: 1'b1, rd: 1'b0};
		@(posedge clk);
		#DRIVE_DLY;
		cpu_bus = '0;
	endtask

	// Read strobe, byte taken mid cycle after the sample edge
	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		cpu_bus = '{addr: addr, wdata: 8'h00, wr: 1'b0, rd: 1'b1};
		#(PERIOD / 2 - DRIVE_DLY);
		status_pulse = ppu_status_read;
		@(posedge clk);
		#DRIVE_DLY;
		cpu_bus = '0;
		#(PERIOD / 2 - DRIVE_DLY);
		data = cpu_data_out;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// PPU side ports answer one edge later
	task automatic vram_port_read(input logic [15:0] addr, output logic [7:0] data);
		vram_ppu_addr = addr;
		@(posedge clk);
		#(PERIOD / 2);
		data = vram_ppu_data;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic oam_port_read(input logic [7:0] addr, output logic [7:0] data);
		oam_ppu_addr = addr;
		@(posedge clk);
		#(PERIOD / 2);
		data = oam_ppu_data;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Status read first so the address goes high byte then low byte
	task automatic set_vaddr(input logic [15:0] addr);
		logic [7:0] unused;
		bus_read(16'h2002, unused);
		bus_write(16'h2006, addr[15:8]);
		bus_write(16'h2006, addr[7:0]);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d mismatches", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	////////////////////
	// Directed tests

	task automatic wram_readback();
		logic [7:0]  model [2048];
		logic [10:0] offs [8];
		logic [15:0] mirror;
		logic [7:0]  got;
		for (int i = 0; i < 8; i++) begin
			offs[i] = 11'($random(seed));
			model[offs[i]] = 8'($random(seed));
			bus_write({5'd0, offs[i]}, model[offs[i]]);
		end
		for (int i = 0; i < 8; i++) begin
			// Plain, then the 0x0800 and 0x1800 mirrors in turn
			mirror = (i % 3 == 0) ? 16'h0000 : ((i % 3 == 1) ? 16'h0800 : 16'h1800);
			bus_read({5'd0, offs[i]} | mirror, got);
			check_byte("cpu_data_out", got, model[offs[i]]);
		end
		report_test("work ram");
	endtask

	task automatic register_access();
		logic [7:0] c1;
		logic [7:0] c2;
		logic [7:0] sx;
		logic [7:0] sy;
		logic [7:0] sx2;
		logic [7:0] stat;
		logic [7:0] got;
		c1 = 8'($random(seed));
		c2 = 8'($random(seed));
		bus_write(16'h2000, c1);
		bus_write(16'h2001, c2);
		check_byte("ppu_ctrl1", ppu_ctrl1, c1);
		check_byte("ppu_ctrl2", ppu_ctrl2, c2);
		// Read back through the register mirrors
		bus_read(16'h2008, got);
		check_byte("cpu_data_out", got, c1);
		bus_read(16'h3009, got);
		check_byte("cpu_data_out", got, c2);
		// Toggle clear after reset, low byte first
		sx = 8'($random(seed));
		sy = 8'($random(seed));
		bus_write(16'h2005, sx);
		bus_write(16'h2005, sy);
		check_word("ppu_scroll", ppu_scroll, {sy, sx});
		// Leave the toggle set, then clear it by a status read
		bus_write(16'h2005, 8'hA5);
		stat = 8'($random(seed));
		ppu_status = stat;
		bus_read(16'h2002, got);
		check_byte("cpu_data_out", got, stat);
		check_byte("ppu_status_read", {7'd0, status_pulse}, 8'h01);
		check_byte("ppu_status_read", {7'd0, ppu_status_read}, 8'h00);
		sx2 = 8'($random(seed));
		bus_write(16'h2005, sx2);
		check_word("ppu_scroll", ppu_scroll, {sy, sx2});
		report_test("ppu registers");
	endtask

	task automatic vram_cpu_port();
		logic [7:0] row [8];
		logic [7:0] col [5];
		logic [7:0] pal [3];
		logic [7:0] vbuf;
		logic [7:0] got;
		bus_write(16'h2000, 8'h00);
		set_vaddr(16'h2100);
		for (int i = 0; i < 8; i++) begin
			row[i] = 8'($random(seed));
			bus_write(16'h2007, row[i]);
		end
		// Column step of 32
		bus_write(16'h2000, 8'h04);
		set_vaddr(16'h2200);
		for (int i = 0; i < 5; i++) begin
			col[i] = 8'($random(seed));
			bus_write(16'h2007, col[i]);
		end
		bus_write(16'h2000, 8'h00);
		set_vaddr(16'h3F01);
		for (int i = 0; i < 3; i++) begin
			pal[i] = 8'($random(seed));
			bus_write(16'h2007, pal[i]);
		end
		// Buffer never loaded since reset
		vbuf = 8'h00;
		set_vaddr(16'h2100);
		for (int i = 0; i < 8; i++) begin
			bus_read(16'h2007, got);
			check_byte("cpu_data_out", got, vbuf);
			vbuf = row[i];
		end
		bus_write(16'h2000, 8'h04);
		set_vaddr(16'h2200);
		for (int i = 0; i < 5; i++) begin
			bus_read(16'h2007, got);
			check_byte("cpu_data_out", got, vbuf);
			vbuf = col[i];
		end
		// Palette bytes skip the buffer
		bus_write(16'h2000, 8'h00);
		set_vaddr(16'h3F01);
		for (int i = 0; i < 3; i++) begin
			bus_read(16'h2007, got);
			check_byte("cpu_data_out", got, pal[i]);
		end
		report_test("vram cpu port");
	endtask

	task automatic vram_mirroring();
		logic [7:0] h_byte;
		logic [7:0] v_byte;
		logic [7:0] p_byte;
		logic [7:0] got;
		mirror_mode = MIRROR_H;
		h_byte = 8'($random(seed));
		set_vaddr(16'h2005);
		bus_write(16'h2007, h_byte);
		vram_port_read(16'h2405, got);
		check_byte("vram_ppu_data", got, h_byte);
		mirror_mode = MIRROR_V;
		v_byte = 8'($random(seed));
		set_vaddr(16'h2005);
		bus_write(16'h2007, v_byte);
		vram_port_read(16'h2805, got);
		check_byte("vram_ppu_data", got, v_byte);
		// Sprite backdrop aliases the background one
		p_byte = 8'($random(seed));
		set_vaddr(16'h3F10);
		bus_write(16'h2007, p_byte);
		vram_port_read(16'h3F00, got);
		check_byte("vram_ppu_data", got, p_byte);
		report_test("vram mirroring");
	endtask

	task automatic sprite_memory();
		logic [7:0] spr [6];
		logic [7:0] base;
		logic [7:0] got;
		// Run crosses the wrap at 256
		base = 8'hFD;
		bus_write(16'h2003, base);
		for (int i = 0; i < 6; i++) begin
			spr[i] = 8'($random(seed));
			bus_write(16'h2004, spr[i]);
		end
		bus_read(16'h2003, got);
		check_byte("cpu_data_out", got, 8'(base + 8'd6));
		for (int i = 0; i < 6; i++) begin
			oam_port_read(8'(base + 8'(i)), got);
			check_byte("oam_ppu_data", got, spr[i]);
		end
		report_test("sprite memory");
	endtask

	task automatic joypad_serial();
		logic [7:0] got;
		logic [7:0] exp;
		joy_buttons = 16'($random(seed));
		bus_write(16'h4016, 8'h01);
		bus_write(16'h4016, 8'h00);
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 10; i++) begin
				bus_read(16'h4016 + 16'(p), got);
				// Buttons from bit 0, then ones
				exp = (i < 8) ? {7'd0, joy_buttons[p][i]} : 8'h01;
				check_byte("cpu_data_out", got, exp);
			end
		end
		report_test("joypads");
	endtask

	////////////////////
	// Main sequence

	initial begin
		rst = 1'b0;
		cpu_bus = '0;
		ppu_status = 8'h00;
		vram_ppu_addr = 16'h0000;
		oam_ppu_addr = 8'h00;
		joy_buttons = '0;
		mirror_mode = MIRROR_H;
		errors = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		status_pulse = 1'b0;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b1;

		wram_readback();
		register_access();
		vram_cpu_port();
		vram_mirroring();
		sprite_memory();
		joypad_serial();

		$display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_decode.f
rtl/mem_pkg.sv
rtl/cpu_addr_map.sv
rtl/vram_mirror.sv
rtl/dual_port_ram.sv
rtl/ppu_reg_file.sv
rtl/joypad_shift.sv
rtl/cpu_read_mux.sv
rtl/mem_decode.sv
test/mem_decode_chk.sv
test/tb_mem_decode.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f mem_decode.f --top-module tb_mem_decode

# Sim status is not trusted, the pass line decides
out=$(./obj_dir/Vtb_mem_decode 2>&1) || true
echo "$out"

if grep -q "ALL TESTS PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
